/* corr_params.svh */
`ifndef CORR_PARAMS_SVH
`define CORR_PARAMS_SVH

// ----------------------------------------
// array geometry
// ----------------------------------------
`define CORR_NUM_ANT        8    // one-bit antennas
`define CORR_NUM_LANES      4    // correlator lanes
`define CORR_PAIRS_PER_LANE 7    // pairs per lane
`define CORR_NUM_PAIRS      28   // 8 choose 2

// datapath widths
`define CORR_ACCUM_BITS     16   // visibility count width
`define CORR_BLOCK_BITS     16   // block-size field
`define CORR_PAIR_BITS      5    // enough for pair 0..27

`endif

/* corr_pkg.sv */
package corr_pkg;

`include "corr_params.svh"

   typedef logic [`CORR_NUM_ANT-1:0]         antenna_t;   // one sign bit per antenna
   typedef logic [`CORR_ACCUM_BITS-1:0]      vis_t;       // count, also checksum
   typedef logic [`CORR_PAIR_BITS-1:0]       pair_idx_t;  // pair 0..27
   typedef logic [2:0]                       slot_idx_t;  // slot in lane 0..6
   typedef logic [$clog2(`CORR_NUM_ANT)-1:0] ant_idx_t;   // antenna number

   typedef struct packed {
      ant_idx_t a;                                        // lower antenna
      ant_idx_t b;                                        // upper antenna
   } ant_pair_t;

   // pairs (a,b) with a < b numbered lexicographically
   function automatic ant_pair_t pair_of(input pair_idx_t k);
      ant_pair_t   p;
      int unsigned n;
      p = '0;
      n = 0;
      for (int i = 0; i < `CORR_NUM_ANT; i++) begin
         for (int j = i + 1; j < `CORR_NUM_ANT; j++) begin
            if (n == k) begin                             // hit the wanted index
               p.a = ant_idx_t'(i);
               p.b = ant_idx_t'(j);
            end
            n++;
         end
      end
      return p;
   endfunction

endpackage

/* vis_rd_if.sv */
`timescale 1ns/1ps

// one lane's held-bank read channel
interface vis_rd_if
   import corr_pkg::*;
   ();

   logic      rd_stb;                      // single-cycle read request
   slot_idx_t slot;                        // slot to read
   vis_t      rd_data;                     // held-bank count
   logic      rd_valid;                    // one cycle after rd_stb

   modport lane_mp (
      input  rd_stb,
      input  slot,
      output rd_data,
      output rd_valid
   );

   modport reader_mp (
      output rd_stb,
      output slot,
      input  rd_data,
      input  rd_valid
   );

endinterface

/* antenna_frontend.sv */
`timescale 1ns/1ps
`include "corr_params.svh"

module antenna_frontend
   import corr_pkg::*;
(
   input  logic                        clk_x,
   input  logic                        arst_n_i,
   input  logic                        enable_i,      // acquisition on
   input  logic [`CORR_BLOCK_BITS-1:0] blocksize_i,   // samples per block - 1
   input  antenna_t                    antenna_i,     // raw signs
   output antenna_t                    sample_o,      // registered signs
   output logic                        sample_vld_o,  // sample_o is live
   output logic                        swap_o,        // last sample of block
   output logic                        switching_o    // host copy of swap_o
);

   antenna_t                    sample_q;             // sample stage
   logic                        vld_q;                // delayed enable
   logic [`CORR_BLOCK_BITS-1:0] cnt_q;                // samples so far in block
   logic                        last_smp;             // block boundary

   // ----------------------------------------
   // input register stage
   // ----------------------------------------
   always_ff @(posedge clk_x) begin
      sample_q <= antenna_i;                          // antenna signs
   end

   always_ff @(posedge clk_x or negedge arst_n_i) begin
      if (!arst_n_i) begin
         vld_q <= 1'b0;
      end else begin
         vld_q <= enable_i;                           // one-cycle delay
      end
   end

   // ----------------------------------------
   // block sample counter
   // ----------------------------------------
   assign last_smp = vld_q && (cnt_q == blocksize_i); // fires with the last sample

   always_ff @(posedge clk_x or negedge arst_n_i) begin
      if (!arst_n_i) begin
         cnt_q <= '0;
      end else if (!vld_q || last_smp) begin
         cnt_q <= '0;                                 // idle or block done
      end else begin
         cnt_q <= cnt_q + 1'b1;
      end
   end

   assign sample_o     = sample_q;
   assign sample_vld_o = vld_q;
   assign swap_o       = last_smp;                    // to the lanes and readback
   assign switching_o  = last_smp;

endmodule

/* correlator_lane.sv */
`timescale 1ns/1ps
`include "corr_params.svh"

module correlator_lane
   import corr_pkg::*;
#(
   parameter int LANE_ID = 0                          // 0..3, picks pair range
)(
   input  logic         clk_x,
   input  logic         arst_n_i,
   input  antenna_t     sample_i,                     // registered signs
   input  logic         sample_vld_i,
   input  logic         swap_i,                       // bank switch with this sample
   vis_rd_if.lane_mp    rd                            // held-bank read port
);

   localparam int NSLOT = `CORR_PAIRS_PER_LANE;

   logic [NSLOT-1:0] agree;                           // xnor per slot
   vis_t             acc_q   [NSLOT];                 // active bank
   vis_t             acc_sum [NSLOT];                 // active + this sample
   vis_t             held_q  [NSLOT];                 // finished block

   // ----------------------------------------
   // pair taps fixed at elaboration
   // ----------------------------------------
   for (genvar g = 0; g < NSLOT; g++) begin : g_slot
      localparam ant_pair_t PAIR = pair_of(pair_idx_t'(LANE_ID * NSLOT + g));

      assign agree[g]   = ~(sample_i[PAIR.a] ^ sample_i[PAIR.b]); // same sign
      assign acc_sum[g] = acc_q[g] + vis_t'(agree[g]);
   end

   // ----------------------------------------
   // active bank
   // ----------------------------------------
   always_ff @(posedge clk_x or negedge arst_n_i) begin
      if (!arst_n_i) begin
         for (int s = 0; s < NSLOT; s++) begin
            acc_q[s] <= '0;
         end
      end else begin
         for (int s = 0; s < NSLOT; s++) begin
            if (!sample_vld_i || swap_i) begin
               acc_q[s] <= '0;                        // restart block
            end else begin
               acc_q[s] <= acc_sum[s];                // count agreement
            end
         end
      end
   end

   // held bank takes the sum including the swap sample
   always_ff @(posedge clk_x) begin
      if (swap_i) begin
         for (int s = 0; s < NSLOT; s++) begin
            held_q[s] <= acc_sum[s];
         end
      end
   end

   // ----------------------------------------
   // read port with one cycle latency
   // ----------------------------------------
   always_ff @(posedge clk_x or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rd.rd_valid <= 1'b0;
      end else begin
         rd.rd_valid <= rd.rd_stb;                    // strobe may come every cycle
      end
   end

   always_ff @(posedge clk_x) begin
      if (rd.rd_stb) begin
         rd.rd_data <= held_q[rd.slot];
      end
   end

endmodule

/* visibility_readback.sv */
`timescale 1ns/1ps
`include "corr_params.svh"

module visibility_readback
   import corr_pkg::*;
(
   input  logic         clk_x,
   input  logic         arst_n_i,
   input  logic         swap_i,                       // start a drain next cycle
   vis_rd_if.reader_mp  lanes [`CORR_NUM_LANES],      // one channel per lane
   input  logic         rd_stb_i,                     // host read
   input  pair_idx_t    rd_addr_i,
   output vis_t         rd_data_o,
   output logic         rd_ack_o,
   output logic         newblock_o,                   // buffer refreshed
   output vis_t         checksum_o                    // sum of all counts
);

   localparam int NLANE = `CORR_NUM_LANES;
   localparam int NSLOT = `CORR_PAIRS_PER_LANE;

   logic             busy_q;                          // strobes going out
   slot_idx_t        slot_q;                          // slot being requested
   slot_idx_t        rsp_slot_q;                      // slot of returning data
   logic             rsp_last_q;                      // last slot returns now
   vis_t             lane_data [NLANE];
   logic [NLANE-1:0] lane_vld;
   vis_t             sum_q;                           // running checksum
   vis_t             beat_sum;                        // running + this beat
   vis_t             vis_buf [`CORR_NUM_PAIRS];       // host-visible buffer

   // fan the request out, gather the answers
   for (genvar g = 0; g < NLANE; g++) begin : g_lane
      assign lanes[g].rd_stb = busy_q;
      assign lanes[g].slot   = slot_q;
      assign lane_data[g]    = lanes[g].rd_data;
      assign lane_vld[g]     = lanes[g].rd_valid;
   end

   // ----------------------------------------
   // drain sequencer
   // ----------------------------------------
   always_ff @(posedge clk_x or negedge arst_n_i) begin
      if (!arst_n_i) begin
         busy_q     <= 1'b0;
         slot_q     <= '0;
         rsp_slot_q <= '0;
         rsp_last_q <= 1'b0;
      end else begin
         rsp_slot_q <= slot_q;                        // matches lane latency
         rsp_last_q <= busy_q && (slot_q == slot_idx_t'(NSLOT - 1));
         if (swap_i) begin
            busy_q <= 1'b1;                           // slot 0 next cycle
            slot_q <= '0;
         end else if (busy_q) begin
            if (slot_q == slot_idx_t'(NSLOT - 1)) begin
               busy_q <= 1'b0;                        // seven strobes sent
            end
            slot_q <= slot_q + 1'b1;
         end
      end
   end

   // ----------------------------------------
   // checksum
   // ----------------------------------------
   always_comb begin
      beat_sum = sum_q;
      for (int l = 0; l < NLANE; l++) begin
         if (lane_vld[l]) begin
            beat_sum = beat_sum + lane_data[l];       // wraps mod 2^16
         end
      end
   end

   always_ff @(posedge clk_x or negedge arst_n_i) begin
      if (!arst_n_i) begin
         sum_q      <= '0;
         checksum_o <= '0;
         newblock_o <= 1'b0;
      end else begin
         if (swap_i) begin
            sum_q <= '0;
         end else if (|lane_vld) begin
            sum_q <= beat_sum;
         end
         if (rsp_last_q) begin
            checksum_o <= beat_sum;                   // publish with newblock
         end
         newblock_o <= rsp_last_q;                    // 9 cycles after swap
      end
   end

   // buffer entry = lane * 7 + slot
   always_ff @(posedge clk_x) begin
      for (int l = 0; l < NLANE; l++) begin
         if (lane_vld[l]) begin
            vis_buf[l * NSLOT + int'(rsp_slot_q)] <= lane_data[l];
         end
      end
   end

   // ----------------------------------------
   // host read port
   // ----------------------------------------
   always_ff @(posedge clk_x or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rd_ack_o <= 1'b0;
      end else begin
         rd_ack_o <= rd_stb_i;                        // always accepted
      end
   end

   always_ff @(posedge clk_x) begin
      if (rd_stb_i) begin
         rd_data_o <= vis_buf[rd_addr_i];             // old value until rewritten
      end
   end

endmodule

/* corr_dsp_top.sv */
`timescale 1ns/1ps
`include "corr_params.svh"

module corr_dsp_top
   import corr_pkg::*;
(
   input  logic                        clk_x,
   input  logic                        arst_n_i,
   input  logic                        enable_i,      // acquisition on
   input  logic [`CORR_BLOCK_BITS-1:0] blocksize_i,   // samples per block - 1
   input  antenna_t                    antenna_i,
   input  logic                        rd_stb_i,
   input  pair_idx_t                   rd_addr_i,
   output vis_t                        rd_data_o,
   output logic                        rd_ack_o,
   output logic                        switching_o,   // bank switch pulse
   output logic                        newblock_o,    // buffer refreshed
   output vis_t                        checksum_o
);

   antenna_t sample;                                  // front end to lanes
   logic     sample_vld;
   logic     swap;

   vis_rd_if rd_bus [`CORR_NUM_LANES] ();             // lane read channels

   antenna_frontend i_frontend (
      .clk_x        (clk_x),
      .arst_n_i     (arst_n_i),
      .enable_i     (enable_i),
      .blocksize_i  (blocksize_i),
      .antenna_i    (antenna_i),
      .sample_o     (sample),
      .sample_vld_o (sample_vld),
      .swap_o       (swap),
      .switching_o  (switching_o)
   );

   // ----------------------------------------
   // correlator lanes
   // ----------------------------------------
   for (genvar g = 0; g < `CORR_NUM_LANES; g++) begin : g_lane
      correlator_lane #(
         .LANE_ID (g)                                 // pairs 7g..7g+6
      ) i_lane (
         .clk_x        (clk_x),
         .arst_n_i     (arst_n_i),
         .sample_i     (sample),
         .sample_vld_i (sample_vld),
         .swap_i       (swap),
         .rd           (rd_bus[g])
      );
   end

   visibility_readback i_readback (
      .clk_x      (clk_x),
      .arst_n_i   (arst_n_i),
      .swap_i     (swap),
      .lanes      (rd_bus),
      .rd_stb_i   (rd_stb_i),
      .rd_addr_i  (rd_addr_i),
      .rd_data_o  (rd_data_o),
      .rd_ack_o   (rd_ack_o),
      .newblock_o (newblock_o),
      .checksum_o (checksum_o)
   );

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
   parameter int PERIOD_NS  = 40,                     // 25 MHz
   parameter int RST_CYCLES = 4                       // reset length in clocks
)(
   output logic clk_x,
   output logic arst_n_o
);

   initial begin
      clk_x = 1'b0;
      forever #(PERIOD_NS / 2) clk_x = ~clk_x;
   end

   initial begin
      arst_n_o = 1'b0;                                // asserted from time 0
      repeat (RST_CYCLES) @(posedge clk_x);
      #2 arst_n_o = 1'b1;                             // released off the edge
   end

endmodule

/* tb_corr_checks.svh */
`ifndef TB_CORR_CHECKS_SVH
`define TB_CORR_CHECKS_SVH

// ----------------------------------------
// compare tasks
// ----------------------------------------
task automatic check_vis(input string name, input vis_t got, input vis_t exp);
   if (got !== exp) begin
      $display("CHECK FAILED %s: got 0x%04h expected 0x%04h", name, got, exp);
      err_cnt++;
   end
endtask

task automatic check_checksum(input string name, input vis_t got, input vis_t exp);
   if (got !== exp) begin
      $display("CHECK FAILED %s: got 0x%04h expected 0x%04h", name, got, exp);
      err_cnt++;
   end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
   if (got !== exp) begin
      $display("CHECK FAILED %s: got 0x%0h expected 0x%0h", name, got, exp);
      err_cnt++;
   end
endtask

task automatic report_error(input string what);
   $display("ERROR: %s", what);                       // plain-words failure
   err_cnt++;
endtask

// ----------------------------------------
// LFSR stimulus on x^17 + x^14 + 1
// ----------------------------------------
logic [16:0] lfsr_q = 17'd70801;                      // fixed seed

function automatic logic lfsr_bit();
   logic fb;
   fb     = lfsr_q[16] ^ lfsr_q[13];
   lfsr_q = {lfsr_q[15:0], fb};                       // one step per bit
   return fb;
endfunction

function automatic antenna_t rand_antenna();
   antenna_t s;
   for (int i = 0; i < `CORR_NUM_ANT; i++) begin
      s[i] = lfsr_bit();
   end
   return s;
endfunction

// reference counts over pairs (a,b) with a < b in lexicographic order
task automatic model_block(input antenna_t smp[$]);
   int k;
   k       = 0;
   exp_sum = '0;
   for (int a = 0; a < `CORR_NUM_ANT; a++) begin
      for (int b = a + 1; b < `CORR_NUM_ANT; b++) begin
         exp_vis[k] = '0;
         foreach (smp[i]) begin
            if (smp[i][a] == smp[i][b]) exp_vis[k]++; // signs agree
         end
         exp_sum = exp_sum + exp_vis[k];              // wraps at 16 bits
         k++;
      end
   end
endtask

`endif

/* tb_corr_dsp.sv */
`timescale 1ns/1ps
`include "corr_params.svh"

module tb_corr_dsp
   import corr_pkg::*;
   ();

   localparam int NPAIR    = `CORR_NUM_PAIRS;
   localparam int LATENCY  = 10;                      // last sample to newblock
   localparam int READ_CYC = 2 * NPAIR;               // strobe plus ack per entry
   localparam int TEST_CYC = 4 + (20 + LATENCY + READ_CYC) + (40 + LATENCY + READ_CYC)
                           + (48 + LATENCY + READ_CYC) + (95 + LATENCY + READ_CYC)
                           + (10 + LATENCY);
   localparam int TIMEOUT_CYC = TEST_CYC + 100;       // margin for idle edges

   logic                        clk_x;
   logic                        arst_n;
   logic                        enable;
   logic [`CORR_BLOCK_BITS-1:0] blocksize;
   antenna_t                    antenna;
   logic                        rd_stb;
   pair_idx_t                   rd_addr;
   vis_t                        rd_data;
   logic                        rd_ack;
   logic                        switching;
   logic                        newblock;
   vis_t                        checksum;

   int   err_cnt    = 0;
   int   err_start  = 0;                              // errors before this test
   int   tests_pass = 0;
   int   tests_fail = 0;
   int   cycle_cnt  = 0;
   int   nb_cnt     = 0;                              // newblock pulses seen
   int   sw_cnt     = 0;                              // switching pulses seen
   vis_t exp_vis [NPAIR];
   vis_t exp_sum;

`include "tb_corr_checks.svh"

   tb_clock_gen i_clock_gen (
      .clk_x    (clk_x),
      .arst_n_o (arst_n)
   );

   corr_dsp_top i_corr_dsp_top (
      .clk_x       (clk_x),
      .arst_n_i    (arst_n),
      .enable_i    (enable),
      .blocksize_i (blocksize),
      .antenna_i   (antenna),
      .rd_stb_i    (rd_stb),
      .rd_addr_i   (rd_addr),
      .rd_data_o   (rd_data),
      .rd_ack_o    (rd_ack),
      .switching_o (switching),
      .newblock_o  (newblock),
      .checksum_o  (checksum)
   );

   // ----------------------------------------
   // pulse counters and watchdog
   // ----------------------------------------
   always @(posedge clk_x) begin
      cycle_cnt <= cycle_cnt + 1;
      if (newblock) nb_cnt <= nb_cnt + 1;
      if (switching) sw_cnt <= sw_cnt + 1;
   end

   always @(posedge clk_x) begin
      if (cycle_cnt >= TIMEOUT_CYC) begin
         $display("ERROR: run stopped after %0d cycles without finishing", cycle_cnt);
         $display("Simulation failed");
         $finish;
      end
   end

   // ----------------------------------------
   // drive and read helpers
   // ----------------------------------------
   task automatic drive_samples(input antenna_t smp[$]);
      foreach (smp[i]) begin
         @(posedge clk_x);
         #2;
         enable  = 1'b1;
         antenna = smp[i];
      end
   endtask

   // drops enable, counts edges until newblock_o
   task automatic finish_block();
      int n;
      n = 0;
      while (n < 4 * LATENCY) begin
         @(posedge clk_x);
         #2;
         enable = 1'b0;
         n++;
         if (newblock) break;
      end
      if (!newblock) begin
         report_error("newblock_o did not rise after the block");
      end else if (n != LATENCY) begin
         report_error($sformatf("newblock_o rose %0d cycles after the last sample", n));
      end
   endtask

   task automatic read_all();
      for (int a = 0; a < NPAIR; a++) begin
         @(posedge clk_x);
         #2;
         check_flag("rd_ack_o", rd_ack, 1'b0);        // no ack without strobe
         rd_stb  = 1'b1;
         rd_addr = pair_idx_t'(a);
         @(posedge clk_x);
         #2;
         rd_stb = 1'b0;
         check_flag("rd_ack_o", rd_ack, 1'b1);        // one cycle after strobe
         check_vis($sformatf("rd_data_o[%0d]", a), rd_data, exp_vis[a]);
      end
      check_checksum("checksum_o", checksum, exp_sum);
   endtask

   task automatic end_test(input string name);
      if (err_cnt == err_start) begin
         tests_pass++;
         $display("test %s: ok", name);
      end else begin
         tests_fail++;
         $display("test %s: %0d errors", name, err_cnt - err_start);
      end
      err_start = err_cnt;
   endtask

   // ----------------------------------------
   // directed tests
   // ----------------------------------------
   task automatic test_reset();
      check_flag("switching_o", switching, 1'b0);
      check_flag("newblock_o", newblock, 1'b0);
      check_flag("rd_ack_o", rd_ack, 1'b0);
      check_checksum("checksum_o", checksum, '0);
      end_test("reset state");
   endtask

   task automatic test_identical();
      antenna_t smp[$];
      int       sw0;
      logic     sign;
      sw0       = sw_cnt;
      blocksize = 16'd19;                             // 20 samples
      for (int i = 0; i < 20; i++) begin
         sign = lfsr_bit();                           // one bit for all antennas
         smp.push_back({`CORR_NUM_ANT{sign}});
      end
      drive_samples(smp);
      finish_block();
      foreach (exp_vis[p]) exp_vis[p] = vis_t'(20);
      exp_sum = vis_t'(560);
      read_all();
      if (sw_cnt - sw0 != 1) report_error("switching_o did not pulse once for the block");
      end_test("identical antennas");
   endtask

   task automatic test_random();
      antenna_t smp[$];
      blocksize = 16'd39;
      for (int i = 0; i < 40; i++) smp.push_back(rand_antenna());
      model_block(smp);
      drive_samples(smp);
      finish_block();
      read_all();
      end_test("random block");
   endtask

   task automatic test_back_to_back();
      antenna_t smp1[$];
      antenna_t smp2[$];
      int       nb0;
      int       sw0;
      nb0       = nb_cnt;
      sw0       = sw_cnt;
      blocksize = 16'd23;
      for (int i = 0; i < 24; i++) smp1.push_back(rand_antenna());
      for (int i = 0; i < 24; i++) smp2.push_back(rand_antenna());
      drive_samples(smp1);
      drive_samples(smp2);                            // no idle gap
      finish_block();
      model_block(smp2);                              // second block only
      read_all();
      if (nb_cnt - nb0 != 2) report_error("newblock_o pulse count differs from block count");
      if (sw_cnt - sw0 != 2) report_error("switching_o pulse count differs from block count");
      end_test("back-to-back blocks");
   endtask

   task automatic test_enable_gating();
      antenna_t part[$];
      antenna_t smp[$];
      int       nb0;
      int       sw0;
      blocksize = 16'd29;
      for (int i = 0; i < 5; i++) part.push_back(rand_antenna());
      drive_samples(part);                            // partial block, then stop
      nb0 = nb_cnt;
      sw0 = sw_cnt;
      repeat (60) begin
         @(posedge clk_x);
         #2;
         enable = 1'b0;
      end
      if (nb_cnt != nb0) report_error("newblock_o pulsed while enable was low");
      if (sw_cnt != sw0) report_error("switching_o pulsed while enable was low");
      for (int i = 0; i < 30; i++) smp.push_back(rand_antenna());
      model_block(smp);                               // partial samples excluded
      drive_samples(smp);
      finish_block();
      read_all();
      end_test("enable gating");
   endtask

   task automatic test_latency();
      antenna_t smp[$];
      blocksize = 16'd9;                              // shortest legal block
      for (int i = 0; i < 10; i++) smp.push_back(rand_antenna());
      model_block(smp);
      drive_samples(smp);
      finish_block();                                 // checks the 10-cycle latency
      check_checksum("checksum_o", checksum, exp_sum);
      end_test("newblock latency");
   endtask

   // ----------------------------------------
   // main sequence
   // ----------------------------------------
   initial begin
      enable    = 1'b0;
      blocksize = '0;
      antenna   = '0;
      rd_stb    = 1'b0;
      rd_addr   = '0;
      @(posedge arst_n);
      test_reset();
      test_identical();
      test_random();
      test_back_to_back();
      test_enable_gating();
      test_latency();
      $display("summary: %0d tests passed, %0d tests failed", tests_pass, tests_fail);
      if (tests_fail == 0 && err_cnt == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

/* compile.f */
+incdir+.
corr_pkg.sv
vis_rd_if.sv
antenna_frontend.sv
correlator_lane.sv
visibility_readback.sv
corr_dsp_top.sv
tb_clock_gen.sv
tb_corr_dsp.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0 -Wno-fatal
TOP       = tb_corr_dsp
FILELIST  = compile.f
OBJ_DIR   = obj_dir
PASS_MSG  = Simulation passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status comes from the search for the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
